// File: Bender.yml
package:
  name: lsu_subsys

sources:
  # packages first, then the design bottom-up
  - src/lsu_pkg.sv
  - src/dbus_pkg.sv
  - src/lsu_lane_align.sv
  - src/lsu.sv
  - src/dbus_ram.sv
  - src/lsu_subsys_top.sv
  - target: test
    files:
      - dv/tb_lsu_subsys.sv

// File: dv/tb_lsu_subsys.sv
// ---------------------------------------------------------------------------
// Self-checking testbench for the LSU and D-bus RAM subsystem.
// The RAM has no reset contents, so every word is stored once before loads.
// The run stops at the first mismatch and a watchdog bounds its length.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_subsys;

	import lsu_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int IN_DLY      = 2;	// inputs change this long after the rising edge
	localparam int HOLD_CYCLES = 4;	// idle cycles after each load in the held-data test
	localparam int NUM_OPS     = RAM_DEPTH_WORDS + 32 + 64 + 8 * 12 + 16 * 6 + 16 * 6
		+ 16 * 2 + 8 * (1 + HOLD_CYCLES);
	localparam int WATCHDOG_NS = NUM_OPS * (RAM_WAIT_CYCLES + 3) * 2 * CLK_PERIOD;

	// predicted outcome of one access
	typedef struct packed {
		logic [CPU_DATA_WIDTH-1:0] rdata;
		logic                      rdata_chk;	// o_rdata is defined in the end cycle
		logic                      err_align;
		logic                      err_bus;
		logic [7:0]                cycles;	// cycles up to and including the end cycle
	} expect_t;

	logic                      clk;
	logic                      nrst;
	logic [CPU_ADDR_WIDTH-1:0] i_addr;
	logic [CPU_DATA_WIDTH-1:0] i_wdata;
	lsu_cmd_e                  i_cmd;
	logic                      i_rnw;
	logic [CPU_DATA_WIDTH-1:0] o_rdata;
	logic                      o_busy;
	logic                      o_err_align;
	logic                      o_err_bus;

	logic [CPU_DATA_WIDTH-1:0] shadow [RAM_DEPTH_WORDS];	// expected RAM contents
	logic [CPU_DATA_WIDTH-1:0] last_load;	// value o_rdata must hold while idle
	logic [31:0]               lfsr_state;
	logic                      pending;	// an access waits for its end cycle
	int                        busy_cycles;
	expect_t                   exp_res;
	int                        errors;

	lsu_subsys_top u_lsu_subsys_top (
		.clk         (clk),
		.nrst        (nrst),
		.i_addr      (i_addr),
		.i_wdata     (i_wdata),
		.i_cmd       (i_cmd),
		.i_rnw       (i_rnw),
		.o_rdata     (o_rdata),
		.o_busy      (o_busy),
		.o_err_align (o_err_align),
		.o_err_bus   (o_err_bus)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < nbits; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);	// one step per bit taken
			val[i]     = lfsr_state[0];
		end
		return val;
	endfunction

	function automatic lsu_cmd_e rand_cmd();
		logic [1:0] pick;
		pick = rand_bits(2);
		return (pick == 2'b00) ? LSU_BYTE : lsu_cmd_e'(pick);	// idle folds onto byte
	endfunction

	// clears the offset bits that the access size does not allow
	function automatic logic [CPU_ADDR_WIDTH-1:0] align_for(input lsu_cmd_e cmd,
		input logic [CPU_ADDR_WIDTH-1:0] raw);
		if (cmd == LSU_HWORD)
			return raw & ~CPU_ADDR_WIDTH'(1);
		if (cmd == LSU_WORD)
			return raw & ~CPU_ADDR_WIDTH'(3);
		return raw;
	endfunction

	function automatic logic [CPU_ADDR_WIDTH-1:0] byte_addr(input int idx, input int off);
		return CPU_ADDR_WIDTH'(idx * 4 + off);
	endfunction

	// reference model, little-endian lanes, zero-extended loads, shadow memory updated on stores
	function automatic expect_t lsu_expect(input lsu_cmd_e cmd,
		input logic [CPU_ADDR_WIDTH-1:0] addr, input logic rnw,
		input logic [CPU_DATA_WIDTH-1:0] wdata);
		expect_t e;
		int      idx;
		int      sh;
		e           = '0;
		idx         = int'(addr >> 2);
		sh          = 8 * addr[1:0];	// bit position of the addressed lane
		e.err_align = (cmd == LSU_HWORD && addr[0]) || (cmd == LSU_WORD && addr[1:0] != 2'b00);
		e.err_bus   = cmd != LSU_IDLE && !e.err_align && addr >= CPU_ADDR_WIDTH'(RAM_SIZE_BYTES);
		e.cycles    = 8'd1;	// refused accesses end in their first cycle
		e.rdata     = last_load;
		e.rdata_chk = 1'b1;
		if (cmd == LSU_IDLE || e.err_align || e.err_bus)
			return e;
		e.cycles = 8'(RAM_WAIT_CYCLES + 1);
		if (rnw)
		begin
			case (cmd)
				LSU_BYTE:  e.rdata = (shadow[idx] >> sh) & 32'h0000_00ff;
				LSU_HWORD: e.rdata = (shadow[idx] >> sh) & 32'h0000_ffff;
				default:   e.rdata = shadow[idx];
			endcase
			last_load = e.rdata;
		end
		else
		begin
			e.rdata_chk = 1'b0;	// a store leaves o_rdata undefined in its end cycle
			case (cmd)
				LSU_BYTE:  shadow[idx][sh +: 8]  = wdata[7:0];
				LSU_HWORD: shadow[idx][sh +: 16] = wdata[15:0];
				default:   shadow[idx]           = wdata;
			endcase
		end
		return e;
	endfunction

	task automatic check_rdata(input string name, input logic [CPU_DATA_WIDTH-1:0] got,
		input logic [CPU_DATA_WIDTH-1:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at %0d ns: %s got 0x%08h, expected 0x%08h", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at %0d ns: %s got %b, expected %b", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_cycles(input string name, input int got, input int exp);
		if (got != exp)
		begin
			errors++;
			$display("MISMATCH at %0d ns: %s got %0d, expected %0d", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	// outputs are sampled at the falling edge, well away from input changes
	always @(negedge clk)
	begin
		if (pending)
		begin
			busy_cycles++;
			if (!o_busy)
			begin
				check_flag("o_err_align", o_err_align, exp_res.err_align);
				check_flag("o_err_bus", o_err_bus, exp_res.err_bus);
				check_cycles("access length", busy_cycles, int'(exp_res.cycles));
				if (exp_res.rdata_chk)
					check_rdata("o_rdata", o_rdata, exp_res.rdata);
				pending = 1'b0;
			end
		end
		else if (nrst && i_cmd == LSU_IDLE)
		begin
			check_flag("o_busy", o_busy, 1'b0);
			check_rdata("o_rdata", o_rdata, last_load);	// held load while idle
		end
	end

	// issues one command and returns once the compare process has seen its end
	task automatic run_access(input lsu_cmd_e cmd, input logic [CPU_ADDR_WIDTH-1:0] addr,
		input logic rnw, input logic [CPU_DATA_WIDTH-1:0] wdata);
		@(posedge clk);
		#(IN_DLY);
		i_cmd       = cmd;
		i_addr      = addr;
		i_rnw       = rnw;
		i_wdata     = wdata;
		exp_res     = lsu_expect(cmd, addr, rnw, wdata);
		busy_cycles = 0;
		pending     = 1'b1;
		wait (pending == 1'b0);
	endtask

	task automatic hold_idle(input int ncycles);
		@(posedge clk);
		#(IN_DLY);
		i_cmd  = LSU_IDLE;
		i_addr = rand_bits(32);	// address noise must not reach o_rdata
		repeat (ncycles) @(posedge clk);
	endtask

	initial
	begin
		lsu_cmd_e                  cmd;
		logic [CPU_ADDR_WIDTH-1:0] addr;
		int                        idx;
		errors     = 0;
		pending    = 1'b0;
		lfsr_state = 32'he835_8f64;
		last_load  = '0;
		nrst       = 1'b0;
		i_cmd      = LSU_IDLE;
		i_addr     = '0;
		i_wdata    = '0;
		i_rnw      = 1'b0;
		for (int i = 0; i < RAM_DEPTH_WORDS; i++)
			shadow[i] = '0;
		repeat (3) @(posedge clk);
		#(IN_DLY);
		nrst = 1'b1;

		// word stores over the whole RAM, then random word stores and loads
		for (int i = 0; i < RAM_DEPTH_WORDS; i++)
			run_access(LSU_WORD, byte_addr(i, 0), 1'b0, rand_bits(32));
		for (int i = 0; i < 32; i++)
			run_access(LSU_WORD, byte_addr(rand_bits(RAM_IDX_WIDTH), 0), 1'b0, rand_bits(32));
		for (int i = 0; i < 64; i++)
			run_access(LSU_WORD, byte_addr(rand_bits(RAM_IDX_WIDTH), 0), 1'b1, '0);

		// byte and halfword stores on every lane, each merged word read back
		for (int i = 0; i < 8; i++)
		begin
			idx = rand_bits(RAM_IDX_WIDTH);
			for (int off = 0; off < 4; off++)
			begin
				run_access(LSU_BYTE, byte_addr(idx, off), 1'b0, rand_bits(32));
				run_access(LSU_WORD, byte_addr(idx, 0), 1'b1, '0);
			end
			for (int off = 0; off < 4; off += 2)
			begin
				run_access(LSU_HWORD, byte_addr(idx, off), 1'b0, rand_bits(32));
				run_access(LSU_WORD, byte_addr(idx, 0), 1'b1, '0);
			end
		end

		// sub-word loads at every legal offset
		for (int i = 0; i < 16; i++)
		begin
			idx = rand_bits(RAM_IDX_WIDTH);
			for (int off = 0; off < 4; off++)
				run_access(LSU_BYTE, byte_addr(idx, off), 1'b1, '0);
			for (int off = 0; off < 4; off += 2)
				run_access(LSU_HWORD, byte_addr(idx, off), 1'b1, '0);
		end

		// misaligned halfwords and words, then a word load of the same location
		for (int i = 0; i < 16; i++)
		begin
			idx = rand_bits(RAM_IDX_WIDTH);
			for (int off = 1; off < 4; off += 2)
				run_access(LSU_HWORD, byte_addr(idx, off), rand_bits(1), rand_bits(32));
			for (int off = 1; off < 4; off++)
				run_access(LSU_WORD, byte_addr(idx, off), rand_bits(1), rand_bits(32));
			run_access(LSU_WORD, byte_addr(idx, 0), 1'b1, '0);
		end

		// out-of-range accesses, then a load of the word the low address bits point at
		for (int i = 0; i < 16; i++)
		begin
			cmd  = rand_cmd();
			addr = align_for(cmd, rand_bits(32) | CPU_ADDR_WIDTH'(RAM_SIZE_BYTES));
			run_access(cmd, addr, rand_bits(1), rand_bits(32));
			run_access(LSU_WORD, byte_addr(int'(addr[RAM_IDX_WIDTH+1:2]), 0), 1'b1, '0);
		end

		// loads followed by idle cycles, o_rdata must keep the extracted value
		for (int i = 0; i < 8; i++)
		begin
			cmd  = rand_cmd();
			addr = align_for(cmd, rand_bits(RAM_IDX_WIDTH + 2));
			run_access(cmd, addr, 1'b1, '0);
			hold_idle(HOLD_CYCLES);
		end

		if (errors == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
src/lsu_pkg.sv
src/dbus_pkg.sv
src/lsu_lane_align.sv
src/lsu.sv
src/dbus_ram.sv
src/lsu_subsys_top.sv
dv/tb_lsu_subsys.sv

// File: src/dbus_pkg.sv
// ---------------------------------------------------------------------------
// D-bus request and response types between the LSU and the data RAM.
// Addresses on the bus are always word-aligned, lanes picked by ben.
// A request stays valid with stable fields until rdy or err is returned.
// ---------------------------------------------------------------------------
`default_nettype none

package dbus_pkg;

	// one bus word, seen as a whole, as byte lanes or as halfword lanes
	typedef union packed {
		logic [lsu_pkg::CPU_DATA_WIDTH-1:0]             w;	// full word
		logic [lsu_pkg::CPU_BEN_WIDTH-1:0][7:0]         b;	// b[0] is bits 7:0
		logic [lsu_pkg::CPU_BEN_WIDTH/2-1:0][15:0]      h;	// h[0] is bits 15:0
	} dbus_word_u;

	// master to slave
	typedef struct packed {
		logic [lsu_pkg::CPU_ADDR_WIDTH-1:0] addr;	// low two bits are always zero
		logic                               cmd;	// request valid
		logic                               rnw;	// high for a read
		logic [lsu_pkg::CPU_BEN_WIDTH-1:0]  ben;	// lanes taking part in the access
		dbus_word_u                         data;	// store data already on its lanes
	} dbus_req_t;

	// slave to master
	typedef struct packed {
		dbus_word_u data;	// read word, valid together with rdy
		logic       rdy;	// transfer done this cycle
		logic       err;	// access refused, ends the transfer
	} dbus_rsp_t;

endpackage

`default_nettype wire

// File: src/dbus_ram.sv
// ---------------------------------------------------------------------------
// Single-port D-bus slave RAM with byte-enabled writes.
// Ready comes RAM_WAIT_CYCLES cycles after the request first appears.
// Addresses at or above the RAM size get an immediate bus error.
// Memory contents are not initialised by reset.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dbus_ram (
	input  wire                      clk,
	input  wire                      nrst,
	input  wire dbus_pkg::dbus_req_t i_req,
	output dbus_pkg::dbus_rsp_t      o_rsp
);

	import lsu_pkg::*;
	import dbus_pkg::*;

	dbus_word_u                    mem [RAM_DEPTH_WORDS];
	logic [RAM_WAIT_CNT_WIDTH-1:0] wait_cnt;	// cycles the current request has waited
	logic [RAM_IDX_WIDTH-1:0]      word_idx;
	logic                          in_range;
	logic                          rsp_rdy;
	logic                          rsp_err;

	// byte offset bits are dropped, the request address is word-aligned
	assign word_idx = i_req.addr[RAM_IDX_WIDTH+1:2];
	assign in_range = i_req.addr < CPU_ADDR_WIDTH'(RAM_SIZE_BYTES);

	// error is decided from the address alone, no waiting
	assign rsp_err = i_req.cmd && !in_range;
	assign rsp_rdy = i_req.cmd && in_range &&
		(wait_cnt == RAM_WAIT_CNT_WIDTH'(RAM_WAIT_CYCLES));

	// counter restarts after every ready or error so back-to-back requests wait again
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			wait_cnt <= '0;
		else if (!i_req.cmd || rsp_rdy || rsp_err)
			wait_cnt <= '0;
		else
			wait_cnt <= wait_cnt + 1'b1;
	end

	// writes land on the ready edge, only on the enabled lanes
	always_ff @(posedge clk)
	begin
		if (rsp_rdy && !i_req.rnw)
		begin
			for (int i = 0; i < CPU_BEN_WIDTH; i++)
			begin
				if (i_req.ben[i])
					mem[word_idx].b[i] <= i_req.data.b[i];
			end
		end
	end

	always_comb
	begin
		o_rsp      = '0;
		o_rsp.rdy  = rsp_rdy;
		o_rsp.err  = rsp_err;
		if (rsp_rdy && i_req.rnw)
			o_rsp.data = mem[word_idx];	// full word, the master picks its lanes
	end

endmodule

`default_nettype wire

// File: src/lsu.sv
// ---------------------------------------------------------------------------
// Load-store unit on the D-bus, one transfer in flight at a time.
// The pipeline must hold its command while o_busy is high.
// Loads are zero-extended; there are no sign-extending loads.
// o_rdata keeps the last load result while the command is idle.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lsu (
	input  wire                               clk,
	input  wire                               nrst,
	input  wire [lsu_pkg::CPU_ADDR_WIDTH-1:0] i_addr,
	input  wire [lsu_pkg::CPU_DATA_WIDTH-1:0] i_wdata,
	input  wire lsu_pkg::lsu_cmd_e            i_cmd,
	input  wire                               i_rnw,
	output logic [lsu_pkg::CPU_DATA_WIDTH-1:0] o_rdata,	// load result, bits above the size are zero
	output logic                              o_busy,
	output logic                              o_err_align,
	output logic                              o_err_bus,
	output dbus_pkg::dbus_req_t               o_req,
	input  wire dbus_pkg::dbus_rsp_t          i_rsp
);

	import lsu_pkg::*;
	import dbus_pkg::*;

	// response wait FSM
	typedef enum logic {
		ST_IDLE = 1'b0,	// nothing outstanding, a new access may start
		ST_WAIT = 1'b1	// request issued, ready not seen yet
	} lsu_state_e;

	lsu_state_e                 state;
	logic                       active;	// an aligned, non-idle access is on the bus
	logic [CPU_BEN_WIDTH-1:0]   lch_ben;	// enables of the last load
	dbus_word_u                 lch_rdata;	// raw word of the last load
	logic [CPU_BEN_WIDTH-1:0]   sel_ben;
	dbus_word_u                 sel_word;

	lsu_lane_align u_lsu_lane_align (
		.i_addr      (i_addr),
		.i_wdata     (i_wdata),
		.i_cmd       (i_cmd),
		.i_rnw       (i_rnw),
		.o_err_align (o_err_align),
		.o_req       (o_req)
	);

	// request cmd is only set for aligned non-idle commands
	assign active    = o_req.cmd && !i_rsp.err;
	assign o_err_bus = i_rsp.err;	// straight from the slave, no latching

	// busy until ready arrives, an error ends the access at once
	assign o_busy = (active || state == ST_WAIT) && !i_rsp.rdy && !i_rsp.err;

	// moves the enabled lanes down to bit 0 and clears everything above
	function automatic logic [CPU_DATA_WIDTH-1:0] extract_load(
		input dbus_word_u             word,
		input logic [CPU_BEN_WIDTH-1:0] ben
	);
		logic [CPU_DATA_WIDTH-1:0] res;
		res = '0;
		unique case (ben)
			4'b0001: res = {24'b0, word.b[0]};
			4'b0010: res = {24'b0, word.b[1]};
			4'b0100: res = {24'b0, word.b[2]};
			4'b1000: res = {24'b0, word.b[3]};
			4'b0011: res = {16'b0, word.h[0]};
			4'b1100: res = {16'b0, word.h[1]};
			4'b1111: res = word.w;
			default: res = '0;	// no load seen yet after reset
		endcase
		return res;
	endfunction

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state     <= ST_IDLE;
			lch_ben   <= '0;
			lch_rdata <= '0;
		end
		else
		begin
			unique case (state)
				ST_IDLE:
				begin
					if (active && !i_rsp.rdy)
					begin
						state <= ST_WAIT;	// slave inserts wait states
						if (o_req.rnw)
							lch_ben <= o_req.ben;	// stores must not disturb the held load
					end
					else if (active && o_req.rnw)
					begin
						// zero-wait completion, take both at once
						lch_ben   <= o_req.ben;
						lch_rdata <= i_rsp.data;
					end
				end
				default:
				begin
					if (i_rsp.rdy)
					begin
						state <= ST_IDLE;
						if (o_req.rnw)
							lch_rdata <= i_rsp.data;
					end
					else if (i_rsp.err)
						state <= ST_IDLE;	// refused access, nothing to keep
				end
			endcase
		end
	end

	// live data while the access runs, the held load once the command goes idle
	always_comb
	begin
		if (active)
		begin
			sel_word = i_rsp.data;
			sel_ben  = o_req.ben;
		end
		else if (state == ST_WAIT)
		begin
			sel_word = i_rsp.data;
			sel_ben  = lch_ben;
		end
		else
		begin
			sel_word = lch_rdata;
			sel_ben  = lch_ben;
		end
	end

	assign o_rdata = extract_load(sel_word, sel_ben);

endmodule

`default_nettype wire

// File: src/lsu_lane_align.sv
// ---------------------------------------------------------------------------
// Turns one CPU load/store command into a D-bus request.
// Fully combinational, no state and no handshake tracking.
// Misaligned halfword or word commands raise o_err_align and no request.
// Store data is placed on its lanes, other lanes are driven to zero.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_lane_align (
	input  wire [lsu_pkg::CPU_ADDR_WIDTH-1:0] i_addr,	// byte address from the pipeline
	input  wire [lsu_pkg::CPU_DATA_WIDTH-1:0] i_wdata,	// store data, right-justified
	input  wire lsu_pkg::lsu_cmd_e            i_cmd,
	input  wire                               i_rnw,
	output logic                              o_err_align,
	output dbus_pkg::dbus_req_t               o_req
);

	import lsu_pkg::*;

	// halfwords need an even address, words need the low two bits clear
	always_comb
	begin
		unique case (i_cmd)
			LSU_HWORD: o_err_align = i_addr[0];
			LSU_WORD:  o_err_align = |i_addr[1:0];
			default:   o_err_align = 1'b0;	// bytes and idle can never be misaligned
		endcase
	end

	// request formation, all fields stay zero unless a real access goes out
	always_comb
	begin
		o_req = '0;
		if (!o_err_align && i_cmd != LSU_IDLE)
		begin
			o_req.addr = {i_addr[CPU_ADDR_WIDTH-1:2], 2'b00};	// bus is word addressed
			o_req.cmd  = 1'b1;
			o_req.rnw  = i_rnw;
			unique case (i_cmd)
				LSU_BYTE:
				begin
					// one-hot enable on the addressed byte lane
					o_req.ben = CPU_BEN_WIDTH'(1) << i_addr[1:0];
					o_req.data.b[i_addr[1:0]] = i_wdata[7:0];
				end
				LSU_HWORD:
				begin
					// pair of lanes, lower or upper half of the word
					o_req.ben = CPU_BEN_WIDTH'(3) << {i_addr[1], 1'b0};
					o_req.data.h[i_addr[1]] = i_wdata[15:0];
				end
				default:
				begin
					o_req.ben    = '1;	// word access uses all lanes
					o_req.data.w = i_wdata;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/lsu_pkg.sv
// ---------------------------------------------------------------------------
// CPU-side sizes, LSU command encoding and data RAM geometry.
// Widths are fixed at 32-bit address and data with four byte lanes.
// RAM sizing and wait states are shared by the RAM and the testbench.
// ---------------------------------------------------------------------------
`default_nettype none

package lsu_pkg;

	// CPU datapath widths
	localparam int CPU_ADDR_WIDTH = 32;
	localparam int CPU_DATA_WIDTH = 32;
	localparam int CPU_BEN_WIDTH  = CPU_DATA_WIDTH / 8;	// one enable per byte lane

	// load-store command coming from the pipeline
	typedef enum logic [1:0] {
		LSU_IDLE  = 2'b00,	// no access this cycle
		LSU_BYTE  = 2'b01,	// 8-bit access, any offset
		LSU_HWORD = 2'b10,	// 16-bit access, even offset only
		LSU_WORD  = 2'b11	// 32-bit access, word-aligned only
	} lsu_cmd_e;

	// data RAM size in 32-bit words
	localparam int RAM_DEPTH_WORDS = 256;

	// byte addresses at or above this limit are answered with a bus error
	localparam int RAM_SIZE_BYTES = RAM_DEPTH_WORDS * CPU_BEN_WIDTH;

	// word index bits taken from the address above the byte offset
	localparam int RAM_IDX_WIDTH = $clog2(RAM_DEPTH_WORDS);

	// wait states before ready, counted from the first request cycle
	localparam int RAM_WAIT_CYCLES = 2;

	// wait counter must reach RAM_WAIT_CYCLES itself
	localparam int RAM_WAIT_CNT_WIDTH = $clog2(RAM_WAIT_CYCLES + 1);

endpackage

`default_nettype wire

// File: src/lsu_subsys_top.sv
// ---------------------------------------------------------------------------
// Data-memory subsystem, the LSU joined to its D-bus RAM.
// Single master, no arbitration and no cache in the path.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_subsys_top (
	input  wire                                clk,
	input  wire                                nrst,
	input  wire [lsu_pkg::CPU_ADDR_WIDTH-1:0]  i_addr,
	input  wire [lsu_pkg::CPU_DATA_WIDTH-1:0]  i_wdata,
	input  wire lsu_pkg::lsu_cmd_e             i_cmd,
	input  wire                                i_rnw,
	output logic [lsu_pkg::CPU_DATA_WIDTH-1:0] o_rdata,
	output logic                               o_busy,
	output logic                               o_err_align,
	output logic                               o_err_bus
);

	import dbus_pkg::*;

	dbus_req_t dbus_req;	// LSU to RAM
	dbus_rsp_t dbus_rsp;	// RAM back to LSU

	lsu u_lsu (
		.clk         (clk),
		.nrst        (nrst),
		.i_addr      (i_addr),
		.i_wdata     (i_wdata),
		.i_cmd       (i_cmd),
		.i_rnw       (i_rnw),
		.o_rdata     (o_rdata),
		.o_busy      (o_busy),
		.o_err_align (o_err_align),
		.o_err_bus   (o_err_bus),
		.o_req       (dbus_req),
		.i_rsp       (dbus_rsp)
	);

	dbus_ram u_dbus_ram (
		.clk   (clk),
		.nrst  (nrst),
		.i_req (dbus_req),
		.o_rsp (dbus_rsp)
	);

endmodule

`default_nettype wire
